// ==== Makefile ====
# Verilator build and run for the vdma testbench

VERILATOR ?= verilator
TOP       ?= tb_vdma
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/vdma_macros.svh ====
`ifndef VDMA_MACROS_SVH
`define VDMA_MACROS_SVH

// bus and pixel widths
`define VDMA_DATA_W     32
`define VDMA_ADDR_W     32
`define VDMA_PIX_W      16

`define VDMA_BURST_LEN  8       // beats per INCR burst

// active image, kept tiny for simulation
`define VDMA_IMG_H      16
`define VDMA_IMG_V      4
`define VDMA_BURSTS_PER_FRAME \
    ((`VDMA_IMG_H * `VDMA_IMG_V * `VDMA_PIX_W) / (`VDMA_DATA_W * `VDMA_BURST_LEN))

// three frame buffers in external memory
`define VDMA_BUF0_BASE  32'h1000_0000
`define VDMA_BUF1_BASE  32'h1100_0000
`define VDMA_BUF2_BASE  32'h1200_0000

`define VDMA_FIFO_DEPTH 32      // beats, ingest and display side

`endif

// ==== list.f ====
+incdir+include
source/vdma_pkg.sv
source/sync_fifo.sv
source/frame_buffer_ctrl.sv
source/pixel_ingest.sv
source/axi_burst_writer.sv
source/axi_burst_reader.sv
source/pixel_display.sv
source/vdma_top.sv
verification/vdma_checker.sv
verification/tb_vdma.sv

// ==== source/axi_burst_reader.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module axi_burst_reader import vdma_pkg::*; (
    input  logic                    M_AXI_ACLK,
    input  logic                    rst_n,
    input  logic                    rd_enable,
    input  logic                    room,
    input  logic [`VDMA_ADDR_W-1:0] burst_addr,
    output axi_ar_t                 ar,
    input  logic                    arready,
    input  axi_r_t                  r,
    output logic                    rready,
    output logic                    burst_done
);

    rd_state_e               state;
    rd_state_e               state_nxt;
    logic [`VDMA_ADDR_W-1:0] araddr;
    logic                    ar_fire;

    assign ar.addr  = araddr;
    assign ar.valid = (state == RD_ADDR);
    assign rready   = (state == RD_DATA);

    assign ar_fire    = ar.valid & arready;
    assign burst_done = rready & r.valid & r.last;

    ////////////////////
    // one burst in flight

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: if (rd_enable && room) state_nxt = RD_ADDR;
            RD_ADDR: if (ar_fire)           state_nxt = RD_DATA;
            RD_DATA: if (burst_done)        state_nxt = RD_IDLE;
            default:                        state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge M_AXI_ACLK or negedge rst_n) begin
        if (!rst_n)
            state <= RD_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (state == RD_IDLE && state_nxt == RD_ADDR)
            araddr <= burst_addr;   // stays put until ar handshake
    end

endmodule

// ==== source/axi_burst_writer.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module axi_burst_writer import vdma_pkg::*; (
    input  logic                                   M_AXI_ACLK,
    input  logic                                   rst_n,
    input  logic [$clog2(`VDMA_FIFO_DEPTH+1)-1:0] level,
    input  logic [`VDMA_DATA_W-1:0]                head,
    output logic                                   pop,
    input  logic [`VDMA_ADDR_W-1:0]                burst_addr,
    output axi_aw_t                                aw,
    input  logic                                   awready,
    output axi_w_t                                 w,
    input  logic                                   wready,
    input  logic                                   bvalid,
    output logic                                   bready,
    output logic                                   burst_done
);

    localparam int LW     = $clog2(`VDMA_FIFO_DEPTH + 1);
    localparam int BEAT_W = $clog2(`VDMA_BURST_LEN);

    wr_state_e               state;
    wr_state_e               state_nxt;
    logic [BEAT_W-1:0]       beat_cnt;
    logic [`VDMA_ADDR_W-1:0] awaddr;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    b_fire;

    assign aw.addr  = awaddr;
    assign aw.valid = (state == WR_ADDR);
    assign w.data   = head;             // fifo head, popped on transfer
    assign w.last   = (beat_cnt == BEAT_W'(`VDMA_BURST_LEN - 1));
    assign w.valid  = (state == WR_DATA);
    assign bready   = (state == WR_RESP);

    assign aw_fire    = aw.valid & awready;
    assign w_fire     = w.valid & wready;
    assign b_fire     = bready & bvalid;
    assign pop        = w_fire;
    assign burst_done = w_fire & w.last;

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (level >= LW'(`VDMA_BURST_LEN)) state_nxt = WR_ADDR;
            WR_ADDR: if (aw_fire)                       state_nxt = WR_DATA;
            WR_DATA: if (burst_done)                    state_nxt = WR_RESP;
            WR_RESP: if (b_fire)                        state_nxt = WR_IDLE;
            default:                                    state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge M_AXI_ACLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == WR_IDLE)
                beat_cnt <= '0;
            else if (w_fire)
                beat_cnt <= beat_cnt + BEAT_W'(1);
        end
    end

    // address captured once per burst, held through the handshake
    always_ff @(posedge M_AXI_ACLK) begin
        if (state == WR_IDLE && state_nxt == WR_ADDR)
            awaddr <= burst_addr;
    end

endmodule

// ==== source/frame_buffer_ctrl.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module frame_buffer_ctrl import vdma_pkg::*; (
    input  logic                    M_AXI_ACLK,
    input  logic                    rst_n,
    input  logic                    wr_burst_done,
    input  logic                    rd_burst_done,
    output logic [`VDMA_ADDR_W-1:0] wr_addr,
    output logic [`VDMA_ADDR_W-1:0] rd_addr,
    output logic                    rd_enable
);

    localparam int BPF   = `VDMA_BURSTS_PER_FRAME;
    localparam int CNT_W = (BPF > 1) ? $clog2(BPF) : 1;
    localparam logic [`VDMA_ADDR_W-1:0] BURST_BYTES =
        `VDMA_ADDR_W'(`VDMA_BURST_LEN * `VDMA_DATA_W / 8);

    logic [CNT_W-1:0] wr_cnt;       // bursts done in current frame
    logic [CNT_W-1:0] rd_cnt;
    buf_sel_t         wr_ptr;
    buf_sel_t         rd_ptr;
    buf_sel_t         done_ptr;     // newest completed frame
    buf_sel_t         rd_ptr_nxt;
    buf_sel_t         wr_free;
    logic             fresh;        // done_ptr not yet shown
    logic             wr_frame_end;
    logic             rd_frame_end;

    function automatic logic [`VDMA_ADDR_W-1:0] buf_base(input buf_sel_t sel);
        case (sel)
            3'b010:  return `VDMA_BUF1_BASE;
            3'b100:  return `VDMA_BUF2_BASE;
            default: return `VDMA_BUF0_BASE;
        endcase
    endfunction

    assign wr_frame_end = wr_burst_done && (wr_cnt == CNT_W'(BPF - 1));
    assign rd_frame_end = rd_burst_done && (rd_cnt == CNT_W'(BPF - 1));

    // reader choice first, the writer then keeps clear of it
    always_comb begin
        rd_ptr_nxt = rd_ptr;
        if (rd_ptr == '0) begin
            if (wr_frame_end)
                rd_ptr_nxt = wr_ptr;        // first finished frame
        end else if (rd_frame_end) begin
            if (wr_frame_end)
                rd_ptr_nxt = wr_ptr;        // finishing right now, newest
            else if (fresh)
                rd_ptr_nxt = done_ptr;
        end
    end

    assign wr_free = ~(wr_ptr | rd_ptr_nxt);

    always_ff @(posedge M_AXI_ACLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt   <= '0;
            rd_cnt   <= '0;
            wr_ptr   <= 3'b001;
            rd_ptr   <= '0;
            done_ptr <= '0;
            fresh    <= 1'b0;
        end else begin
            if (wr_burst_done)
                wr_cnt <= wr_frame_end ? '0 : wr_cnt + CNT_W'(1);
            if (rd_burst_done)
                rd_cnt <= rd_frame_end ? '0 : rd_cnt + CNT_W'(1);
            if (wr_frame_end) begin
                done_ptr <= wr_ptr;
                wr_ptr   <= wr_free & (~wr_free + buf_sel_t'(1)); // lowest free buffer
                fresh    <= !(rd_ptr == '0 || rd_frame_end);
            end else if (rd_frame_end) begin
                fresh    <= 1'b0;
            end
            rd_ptr <= rd_ptr_nxt;
        end
    end

    assign wr_addr   = buf_base(wr_ptr) + `VDMA_ADDR_W'(wr_cnt) * BURST_BYTES;
    assign rd_addr   = buf_base(rd_ptr) + `VDMA_ADDR_W'(rd_cnt) * BURST_BYTES;
    assign rd_enable = |rd_ptr;

endmodule

// ==== source/pixel_display.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module pixel_display import vdma_pkg::*; (
    input  logic        M_AXI_ACLK,
    input  logic        rst_n,
    input  axi_r_t      r,
    input  logic        rready,
    output logic        room,
    input  logic        show_ren,
    input  logic        show_en,
    output logic        show_vld,
    output logic [23:0] show_rgb888
);

    localparam int LW = $clog2(`VDMA_FIFO_DEPTH + 1);

    logic [`VDMA_DATA_W-1:0] beat;
    logic [LW-1:0]           level;
    logic                    empty;
    logic                    hi_sel;    // 0 = low pixel of head beat
    logic                    pix_pop;
    logic [`VDMA_PIX_W-1:0]  pix;

    sync_fifo #(
        .WIDTH (`VDMA_DATA_W),
        .DEPTH (`VDMA_FIFO_DEPTH)
    ) u_fifo (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst_n      (rst_n),
        .wr_en      (rready & r.valid),
        .din        (r.data),
        .rd_en      (pix_pop & hi_sel),     // beat leaves after its high pixel
        .dout       (beat),
        .level      (level),
        .full       (),
        .empty      (empty)
    );

    assign room    = (LW'(`VDMA_FIFO_DEPTH) - level) >= LW'(`VDMA_BURST_LEN);
    assign pix_pop = show_ren & ~empty;

    always_ff @(posedge M_AXI_ACLK or negedge rst_n) begin
        if (!rst_n)
            hi_sel <= 1'b0;
        else if (pix_pop)
            hi_sel <= ~hi_sel;
    end

    assign pix         = hi_sel ? beat[31:16] : beat[15:0];
    assign show_vld    = ~empty & show_en;
    // rgb565 -> rgb888, fields left aligned
    assign show_rgb888 = {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000};

endmodule

// ==== source/pixel_ingest.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module pixel_ingest (
    input  logic                                   M_AXI_ACLK,
    input  logic                                   rst_n,
    input  logic [`VDMA_PIX_W-1:0]                 cam_pixel,
    input  logic                                   cam_vld,
    input  logic                                   pop,
    output logic [`VDMA_DATA_W-1:0]                head,
    output logic [$clog2(`VDMA_FIFO_DEPTH+1)-1:0] level
);

    logic [`VDMA_PIX_W-1:0] lo_pix;
    logic                   have_lo;    // low half of the pair is waiting

    always_ff @(posedge M_AXI_ACLK or negedge rst_n) begin
        if (!rst_n)
            have_lo <= 1'b0;
        else if (cam_vld)
            have_lo <= ~have_lo;
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (cam_vld && !have_lo)
            lo_pix <= cam_pixel;
    end

    // pair pushed on its high pixel, lost if the fifo is full
    sync_fifo #(
        .WIDTH (`VDMA_DATA_W),
        .DEPTH (`VDMA_FIFO_DEPTH)
    ) u_fifo (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst_n      (rst_n),
        .wr_en      (cam_vld & have_lo),
        .din        ({cam_pixel, lo_pix}),
        .rd_en      (pop),
        .dout       (head),
        .level      (level),
        .full       (),
        .empty      ()
    );

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 32        // power of two
) (
    input  logic                       M_AXI_ACLK,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  logic [WIDTH-1:0]           din,
    input  logic                       rd_en,
    output logic [WIDTH-1:0]           dout,
    output logic [$clog2(DEPTH+1)-1:0] level,
    output logic                       full,
    output logic                       empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en & ~full;   // overflow dropped
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge M_AXI_ACLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + AW'(1);
            if (do_rd)
                rd_ptr <= rd_ptr + AW'(1);
            level <= level + LW'(do_wr) - LW'(do_rd);
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    assign dout  = mem[rd_ptr];     // head, no read latency
    assign full  = (level == LW'(DEPTH));
    assign empty = (level == '0);

endmodule

// ==== source/vdma_pkg.sv ====
`include "vdma_macros.svh"

package vdma_pkg;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef logic [2:0] buf_sel_t;      // one-hot, all zero = no buffer

    ////////////////////
    // axi channel groups

    typedef struct packed {
        logic [`VDMA_ADDR_W-1:0] addr;
        logic                    valid;
    } axi_aw_t;

    typedef struct packed {
        logic [`VDMA_DATA_W-1:0] data;
        logic                    last;
        logic                    valid;
    } axi_w_t;

    typedef struct packed {
        logic [`VDMA_ADDR_W-1:0] addr;
        logic                    valid;
    } axi_ar_t;

    typedef struct packed {
        logic [`VDMA_DATA_W-1:0] data;
        logic                    last;
        logic                    valid;
    } axi_r_t;

endpackage

// ==== source/vdma_top.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module vdma_top import vdma_pkg::*; (
    input  logic                   M_AXI_ACLK,
    input  logic                   rst_n,
    // camera
    input  logic [`VDMA_PIX_W-1:0] cam_pixel,
    input  logic                   cam_vld,
    // display
    input  logic                   show_ren,
    input  logic                   show_en,
    output logic                   show_vld,
    output logic [23:0]            show_rgb888,
    // axi master
    output axi_aw_t                aw,
    input  logic                   awready,
    output axi_w_t                 w,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready,
    output axi_ar_t                ar,
    input  logic                   arready,
    input  axi_r_t                 r,
    output logic                   rready
);

    localparam int LW = $clog2(`VDMA_FIFO_DEPTH + 1);

    logic [`VDMA_DATA_W-1:0] ing_head;
    logic [LW-1:0]           ing_level;
    logic                    ing_pop;
    logic                    wr_burst_done;
    logic                    rd_burst_done;
    logic [`VDMA_ADDR_W-1:0] wr_addr;
    logic [`VDMA_ADDR_W-1:0] rd_addr;
    logic                    rd_enable;
    logic                    room;      // display fifo can take a burst

    frame_buffer_ctrl u_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .rst_n         (rst_n),
        .wr_burst_done (wr_burst_done),
        .rd_burst_done (rd_burst_done),
        .wr_addr       (wr_addr),
        .rd_addr       (rd_addr),
        .rd_enable     (rd_enable)
    );

    ////////////////////
    // write path

    pixel_ingest u_ingest (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst_n      (rst_n),
        .cam_pixel  (cam_pixel),
        .cam_vld    (cam_vld),
        .pop        (ing_pop),
        .head       (ing_head),
        .level      (ing_level)
    );

    axi_burst_writer u_writer (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst_n      (rst_n),
        .level      (ing_level),
        .head       (ing_head),
        .pop        (ing_pop),
        .burst_addr (wr_addr),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .burst_done (wr_burst_done)
    );

    ////////////////////
    // read path

    axi_burst_reader u_reader (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst_n      (rst_n),
        .rd_enable  (rd_enable),
        .room       (room),
        .burst_addr (rd_addr),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready),
        .burst_done (rd_burst_done)
    );

    pixel_display u_display (
        .M_AXI_ACLK  (M_AXI_ACLK),
        .rst_n       (rst_n),
        .r           (r),
        .rready      (rready),
        .room        (room),
        .show_ren    (show_ren),
        .show_en     (show_en),
        .show_vld    (show_vld),
        .show_rgb888 (show_rgb888)
    );

endmodule

// ==== verification/tb_vdma.sv ====
`timescale 1ns/10ps
`include "vdma_macros.svh"

module tb_vdma import vdma_pkg::*; ();

    localparam int PIX_PER_FRAME = `VDMA_IMG_H * `VDMA_IMG_V;
    localparam int FRAME_BYTES   = PIX_PER_FRAME * `VDMA_PIX_W / 8;
    localparam int BURST_BYTES   = `VDMA_BURST_LEN * `VDMA_DATA_W / 8;
    localparam int BPF           = `VDMA_BURSTS_PER_FRAME;
    localparam int NUM_FRAMES    = 6;
    localparam int MAX_CYCLES    = 4 * NUM_FRAMES * 2 * PIX_PER_FRAME; // camera at half rate

    logic                   M_AXI_ACLK;
    logic                   rst_n;
    logic [`VDMA_PIX_W-1:0] cam_pixel;
    logic                   cam_vld;
    logic                   show_ren;
    logic                   show_en;
    logic                   show_vld;
    logic [23:0]            show_rgb888;
    axi_aw_t                aw;
    axi_w_t                 w;
    axi_ar_t                ar;
    axi_r_t                 r;
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic                   arready;
    logic                   rready;

    logic [31:0] lfsr = 32'h1cef_f3f3;
    logic [31:0] mem [logic [31:0]];    // memory model keyed by beat byte address
    int cam_frame = 0;
    int cam_idx = 0;
    int wr_k = 0;                       // bursts done in the frame being written
    int wr_beat = 0;
    int wr_pix = 0;
    int wr_frame = 0;
    int wr_buf = -1;
    logic [31:0] wr_addr = '0;
    logic b_wait = 1'b0;
    int rd_k = 0;
    int rd_buf = -1;                    // -1 between reader frames
    int r_beat = 0;
    int r_shown = 0;
    logic r_busy = 1'b0;
    logic [31:0] rd_addr = '0;
    int done_frame [3] = '{-1, -1, -1}; // camera frame held by each buffer
    int done_cnt = 0;
    int disp_q [$];                     // expected frame per displayed frame
    int disp_idx = 0;
    int disp_frames = 0;
    int cycles = 0;

    vdma_top uut (.*);

    bind vdma_top vdma_checker u_chk (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst_n      (rst_n),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .ar         (ar),
        .arready    (arready),
        .rready     (rready),
        .show_vld   (show_vld)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic lfsr_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] base_of(input int i);
        case (i)
            0:       return `VDMA_BUF0_BASE;
            1:       return `VDMA_BUF1_BASE;
            default: return `VDMA_BUF2_BASE;
        endcase
    endfunction

    function automatic int buffer_of(input logic [31:0] addr);
        int i;
        for (i = 0; i < 3; i++)
            if (addr - base_of(i) < 32'(FRAME_BYTES))
                return i;
        return -1;
    endfunction

    function automatic logic [15:0] pixel_of(input int f, input int n);
        return {4'(f), 12'(n)};
    endfunction

    function automatic logic [23:0] rgb888_of(input logic [15:0] p);
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        red   = 8'(p[15:11]) << 3;  // field moved to the top of its byte
        green = 8'(p[10:5]) << 2;
        blue  = 8'(p[4:0]) << 3;
        return {red, green, blue};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t: %s", $time, msg));
    endtask

    ////////////////////
    // write side

    task automatic check_aw();
        int b;
        b = buffer_of(aw.addr);
        assert (b >= 0) else mismatch($sformatf("AW address %h outside the buffers", aw.addr));
        assert (aw.addr - base_of(b) == 32'(wr_k * BURST_BYTES))
            else mismatch($sformatf("AW address %h is not burst %0d", aw.addr, wr_k));
        if (wr_k == 0) begin
            assert (b != wr_buf) else mismatch($sformatf("writer stayed in buffer %0d", b));
            wr_buf = b;
        end else begin
            assert (b == wr_buf) else mismatch($sformatf("AW left buffer %0d mid frame", wr_buf));
        end
        assert (b != rd_buf) else mismatch($sformatf("AW into displayed buffer %0d", b));
        wr_addr = aw.addr;
        wr_beat = 0;
    endtask

    task automatic check_w();
        logic [31:0] exp;
        exp = {pixel_of(wr_frame, wr_pix + 1), pixel_of(wr_frame, wr_pix)};
        assert (w.data == exp) else mismatch($sformatf("W data %h, expected %h", w.data, exp));
        assert (w.last == (wr_beat == `VDMA_BURST_LEN - 1))
            else mismatch($sformatf("W last %b on beat %0d", w.last, wr_beat));
        mem[wr_addr + 32'(wr_beat * 4)] = w.data;
        wr_pix += 2;
        wr_beat++;
        if (w.last) begin
            b_wait = 1'b1;
            wr_k++;
            if (wr_k == BPF) begin      // frame complete in memory
                wr_k = 0;
                done_frame[wr_buf] = wr_frame;
                done_cnt++;
                wr_frame++;
                wr_pix = 0;
            end
        end
    endtask

    ////////////////////
    // read side

    task automatic check_ar();
        int b;
        b = buffer_of(ar.addr);
        assert (b >= 0) else mismatch($sformatf("AR address %h outside the buffers", ar.addr));
        assert (ar.addr - base_of(b) == 32'(rd_k * BURST_BYTES))
            else mismatch($sformatf("AR address %h is not burst %0d", ar.addr, rd_k));
        if (rd_k == 0) begin
            assert (done_cnt > 0 && done_frame[b] >= 0)
                else mismatch($sformatf("AR into buffer %0d with no complete frame", b));
            assert (!(wr_k != 0 && b == wr_buf))
                else mismatch($sformatf("AR into buffer %0d while it is written", b));
            rd_buf = b;
            disp_q.push_back(done_frame[b]);
        end else begin
            assert (b == rd_buf) else mismatch($sformatf("AR left buffer %0d mid frame", rd_buf));
        end
        rd_k = (rd_k + 1) % BPF;
        rd_addr = ar.addr;
        r_beat = 0;
        r_busy = 1'b1;
    endtask

    task automatic take_r();
        logic [31:0] a;
        a = rd_addr + 32'(r_beat * 4);
        assert (mem.exists(a)) else mismatch($sformatf("read of unwritten address %h", a));
        r_beat++;
        if (r.last) begin
            r_busy = 1'b0;
            if (rd_k == 0)
                rd_buf = -1;    // reader frame over
        end
    endtask

    task automatic check_pixel();
        logic [15:0] exp_pix;
        assert (disp_q.size() > 0) else abort_run("display gave a pixel before any frame was read");
        exp_pix = pixel_of(disp_q[0], disp_idx);
        assert (show_rgb888 == rgb888_of(exp_pix))
            else mismatch($sformatf("display pixel %0d got %h, expected %h",
                                    disp_idx, show_rgb888, rgb888_of(exp_pix)));
        disp_idx++;
        if (disp_idx == PIX_PER_FRAME) begin
            disp_idx = 0;
            disp_q.delete(0);
            disp_frames++;
        end
    endtask

    // all dut inputs change here on the falling edge
    task automatic drive_cycle();
        logic [31:0] a;
        cam_vld = 1'b0;
        if (cam_frame < NUM_FRAMES && lfsr_bit()) begin
            cam_vld   = 1'b1;
            cam_pixel = pixel_of(cam_frame, cam_idx);
            cam_idx++;
            if (cam_idx == PIX_PER_FRAME) begin
                cam_idx = 0;
                cam_frame++;
            end
        end
        awready = lfsr_bit();
        wready  = lfsr_bit() | lfsr_bit();
        arready = lfsr_bit();
        if (!b_wait)
            bvalid = 1'b0;
        else if (!bvalid)
            bvalid = lfsr_bit();    // random response delay
        if (!r_busy) begin
            r.valid = 1'b0;
        end else if (!r.valid || r_beat != r_shown) begin
            r.valid = lfsr_bit();   // random beat gap
            r_shown = r_beat;
        end
        a = rd_addr + 32'(r_beat * 4);
        r.data   = mem.exists(a) ? mem[a] : 32'h0;
        r.last   = (r_beat == `VDMA_BURST_LEN - 1);
        show_en  = 1'b1;
        show_ren = lfsr_bit();
    endtask

    initial begin
        M_AXI_ACLK = 1'b0;
        forever #50 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    initial begin
        rst_n     = 1'b0;
        cam_pixel = '0;
        cam_vld   = 1'b0;
        show_ren  = 1'b0;
        show_en   = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        arready   = 1'b0;
        r         = '0;
        repeat (4) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        rst_n = 1'b1;
        forever begin
            drive_cycle();
            @(negedge M_AXI_ACLK);
            if (uut.u_chk.fail_cnt != 0)
                abort_run("a protocol assertion in the checker failed");
        end
    end

    // handshakes taken on the rising edge
    always @(posedge M_AXI_ACLK) begin
        if (rst_n) begin
            cycles++;
            if (cycles > MAX_CYCLES)
                abort_run($sformatf("timeout after %0d cycles, %0d frames written, %0d shown",
                                    cycles, wr_frame, disp_frames));
            if (aw.valid && awready)
                check_aw();
            if (w.valid && wready)
                check_w();
            if (bvalid && bready)
                b_wait = 1'b0;
            if (r.valid && rready)
                take_r();
            if (ar.valid && arready)
                check_ar();
            if (show_vld && show_ren)
                check_pixel();
        end
    end

    initial begin
        wait (rst_n);
        wait (wr_frame == NUM_FRAMES && disp_frames >= 3);
        @(negedge M_AXI_ACLK);
        if (uut.u_chk.fail_cnt != 0) begin
            abort_run("a protocol assertion in the checker failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== verification/vdma_checker.sv ====
`timescale 1ns/10ps

module vdma_checker import vdma_pkg::*; (
    input  logic    M_AXI_ACLK,
    input  logic    rst_n,
    input  axi_aw_t aw,
    input  logic    awready,
    input  axi_w_t  w,
    input  logic    wready,
    input  logic    bvalid,
    input  logic    bready,
    input  axi_ar_t ar,
    input  logic    arready,
    input  logic    rready,
    input  logic    show_vld
);

    int unsigned fail_cnt = 0;      // failed assertions so far

    ////////////////////
    // reset state

    reset_quiet: assert property (@(posedge M_AXI_ACLK)
        (!rst_n || $rose(rst_n)) |->
            !(aw.valid || w.valid || bready || ar.valid || rready || show_vld))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("handshake outputs active in or right after reset");
        end

    ////////////////////
    // valid holds and payload is stable until ready

    aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!rst_n)
        (aw.valid && !awready) |=> (aw.valid && $stable(aw.addr)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("aw payload changed or valid dropped before awready");
        end

    w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!rst_n)
        (w.valid && !wready) |=> (w.valid && $stable(w.data) && $stable(w.last)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("w payload changed or valid dropped before wready");
        end

    ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!rst_n)
        (ar.valid && !arready) |=> (ar.valid && $stable(ar.addr)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ar payload changed or valid dropped before arready");
        end

    b_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!rst_n)
        (bready && !bvalid) |=> bready)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("bready dropped before the write response");
        end

endmodule
